/* flist.f */
+incdir+.
rv32_pkg.sv
rv32_int_alu.sv
rv32_branch_unit.sv
rv32_exec_stage.sv
rv32_mem_stage.sv
rv32_exec_top.sv
rv32_exec_assert.sv
tb_rv32_exec.sv

/* Bender.yml */
package:
  name: rv32_exec_slice

sources:
  - include_dirs:
      - .
    files:
      - rv32_pkg.sv
      - rv32_int_alu.sv
      - rv32_branch_unit.sv
      - rv32_exec_stage.sv
      - rv32_mem_stage.sv
      - rv32_exec_top.sv
  - target: test
    files:
      - rv32_exec_assert.sv
      - tb_rv32_exec.sv

/* tb_rv32_exec.sv */
/*
 * Testbench for the execute slice: shadow register file and memory,
 * ALU, forwarding, branch and memory stimulus with writeback checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_rv32_exec;

    logic                           clk;
    logic                           resetn;
    rv32_pkg::decoded_buffer_data_t decoded_data;
    logic                           do_jump;
    rv32_pkg::rv32_word             jump_addr;
    rv32_pkg::mem_buffer_data_t     mem_buff;

    // Shadow architectural state
    rv32_pkg::rv32_word regs [32];
    rv32_pkg::rv32_word smem [rv32_pkg::DMEM_WORDS];
    logic               smem_ok [rv32_pkg::DMEM_WORDS];
    rv32_pkg::rv32_word pc;
    logic [4:0]         prev_rd [2];

    rv32_pkg::rv32_word             exp_wb [$];
    logic                           exp_chk [$];
    rv32_pkg::decoded_buffer_data_t issued [$];
    int                             mismatches;
    int                             timeouts;

    rv32_exec_top u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .decoded_data (decoded_data),
        .do_jump      (do_jump),
        .jump_addr    (jump_addr),
        .mem_buff     (mem_buff)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        mismatches++;
    endtask

    function automatic logic [4:0] rand_reg();
        return 5'(1 + $urandom_range(30));
    endfunction

    function automatic rv32_pkg::rv32_word sext12(input rv32_pkg::rv32_word r);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Instruction word in the base ISA layout around a chosen immediate
    function automatic rv32_pkg::rv32_word encode(input rv32_pkg::instr_type_t f,
            input rv32_pkg::rv32_word imm, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        rv32_pkg::rv32_word w;
        case (f)
            rv32_pkg::INSTR_R_TYPE: w = {7'b0, rs2, rs1, 3'b0, rd, 7'h33};
            rv32_pkg::INSTR_I_TYPE: w = {imm[11:0], rs1, 3'b0, rd, 7'h13};
            rv32_pkg::INSTR_S_TYPE: w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
            rv32_pkg::INSTR_B_TYPE: w = {imm[12], imm[10:5], rs2, rs1, 3'b0,
                                         imm[4:1], imm[11], 7'h63};
            rv32_pkg::INSTR_U_TYPE: w = {imm[31:12], rd, 7'h37};
            default:                w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
        endcase
        return w;
    endfunction

    function automatic rv32_pkg::rv32_word ref_alu(input rv32_pkg::int_alu_op_t op,
            input rv32_pkg::rv32_word a, input rv32_pkg::rv32_word b);
        case (op)
            rv32_pkg::ADD:   return a + b;
            rv32_pkg::SUB:   return a - b;
            rv32_pkg::SLL:   return a << b[4:0];
            rv32_pkg::SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32_pkg::SLTU:  return (a < b) ? 32'd1 : 32'd0;
            rv32_pkg::XOR:   return a ^ b;
            rv32_pkg::SRL:   return a >> b[4:0];
            rv32_pkg::SRA:   return $signed(a) >>> b[4:0];
            rv32_pkg::OR:    return a | b;
            rv32_pkg::AND:   return a & b;
            rv32_pkg::PASS2: return b;
            default:         return '0;
        endcase
    endfunction

    function automatic logic ref_branch(input rv32_pkg::branch_op_t op,
            input rv32_pkg::rv32_word a, input rv32_pkg::rv32_word b);
        case (op)
            rv32_pkg::BEQ:       return a == b;
            rv32_pkg::BNE:       return a != b;
            rv32_pkg::BLT:       return $signed(a) < $signed(b);
            rv32_pkg::BGE:       return $signed(a) >= $signed(b);
            rv32_pkg::BLTU:      return a < b;
            rv32_pkg::BGEU:      return a >= b;
            rv32_pkg::BR_ALWAYS: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    // Nearest in-flight writer of rs wins
    function automatic rv32_pkg::bypass_sel_t bypass_for(input logic [4:0] rs);
        if (rs == 5'd0) begin
            return rv32_pkg::BYPASS_NONE;
        end else if (rs == prev_rd[0]) begin
            return rv32_pkg::BYPASS_EXEC_BUFF;
        end else if (rs == prev_rd[1]) begin
            return rv32_pkg::BYPASS_MEM_BUFF;
        end
        return rv32_pkg::BYPASS_NONE;
    endfunction

    function automatic int pending_checks();
        int count;
        count = 0;
        foreach (exp_chk[i]) count += int'(exp_chk[i]);
        return count;
    endfunction

    task automatic issue(input rv32_pkg::decoded_instr_t c, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input rv32_pkg::rv32_word imm,
            input logic chk_wb, input rv32_pkg::rv32_word wb,
            input logic jump, input logic chk_addr, input rv32_pkg::rv32_word addr);
        rv32_pkg::decoded_buffer_data_t d;
        rv32_pkg::decoded_buffer_data_t prior;
        rv32_pkg::rv32_word             want;
        logic                           chk;
        c.bypass_rs1    = bypass_for(rs1);
        c.bypass_rs2    = bypass_for(rs2);
        d.instr         = encode(c.t, imm, rd, rs1, rs2);
        d.pc            = pc;
        d.decoded_instr = c;
        // Stale values on bypassed operands
        d.reg1 = (c.bypass_rs1 == rv32_pkg::BYPASS_NONE) ? regs[rs1] : ~regs[rs1];
        d.reg2 = (c.bypass_rs2 == rv32_pkg::BYPASS_NONE) ? regs[rs2] : ~regs[rs2];
        @(posedge clk);
        decoded_data <= d;
        exp_wb.push_back(wb);
        exp_chk.push_back(chk_wb);
        issued.push_back(d);
        if (rd != 5'd0) begin
            regs[rd] = wb;
        end
        prev_rd[1] = prev_rd[0];
        prev_rd[0] = rd;
        pc = pc + 32'd4;
        @(negedge clk);
        if (do_jump !== jump) begin
            report_mismatch($sformatf("do_jump %b, expected %b", do_jump, jump));
        end
        if (chk_addr && jump_addr !== addr) begin
            report_mismatch($sformatf("jump_addr %h, expected %h", jump_addr, addr));
        end
        // Writeback of the instruction issued two cycles ago
        if (exp_wb.size() > 2) begin
            want  = exp_wb.pop_front();
            chk   = exp_chk.pop_front();
            prior = issued.pop_front();
            if (chk && mem_buff.wb_result !== want) begin
                report_mismatch($sformatf("wb_result %h, expected %h",
                                          mem_buff.wb_result, want));
            end
            if (mem_buff.instr !== prior.instr || mem_buff.pc !== prior.pc ||
                    mem_buff.decoded_instr !== prior.decoded_instr) begin
                report_mismatch($sformatf("pc %h instr %h, expected pc %h instr %h",
                                          mem_buff.pc, mem_buff.instr,
                                          prior.pc, prior.instr));
            end
        end
    endtask

    task automatic issue_nop(input logic chk_wb);
        issue(rv32_pkg::create_nop_ctrl(), 5'd0, 5'd0, 5'd0, '0, chk_wb, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic run_alu(input rv32_pkg::int_alu_op_t op, input rv32_pkg::instr_type_t f,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        rv32_pkg::decoded_instr_t c;
        rv32_pkg::rv32_word       imm;
        rv32_pkg::rv32_word       a;
        rv32_pkg::rv32_word       b;
        logic [4:0]               s1;
        logic [4:0]               s2;
        c               = rv32_pkg::create_nop_ctrl();
        c.t             = f;
        c.int_alu_op    = op;
        c.wb_result_src = rv32_pkg::WB_INT_ALU;
        imm = '0;
        s1  = rs1;
        s2  = rs2;
        if (f == rv32_pkg::INSTR_R_TYPE) begin
            c.int_alu_i2 = rv32_pkg::ALU_IN_REG_2;
        end else if (f == rv32_pkg::INSTR_I_TYPE) begin
            s2  = 5'd0;
            imm = sext12($urandom);
        end else begin
            // LUI against zero, AUIPC against the PC
            s1  = 5'd0;
            s2  = 5'd0;
            imm = $urandom & 32'hffff_f000;
            if (op == rv32_pkg::PASS2) begin
                c.int_alu_i1 = rv32_pkg::ALU_IN_ZERO;
            end else begin
                c.int_alu_i1 = rv32_pkg::ALU_IN_PC;
            end
        end
        a = (c.int_alu_i1 == rv32_pkg::ALU_IN_PC) ? pc : regs[s1];
        b = (f == rv32_pkg::INSTR_R_TYPE) ? regs[s2] : imm;
        issue(c, rd, s1, s2, imm, 1'b1, ref_alu(op, a, b), 1'b0, 1'b0, '0);
    endtask

    task automatic run_branch(input rv32_pkg::branch_op_t op, input rv32_pkg::rv32_word a,
            input rv32_pkg::rv32_word b);
        rv32_pkg::decoded_instr_t c;
        rv32_pkg::rv32_word       r;
        rv32_pkg::rv32_word       imm;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        c            = rv32_pkg::create_nop_ctrl();
        c.t          = rv32_pkg::INSTR_B_TYPE;
        c.int_alu_i1 = rv32_pkg::ALU_IN_PC;
        c.branch_op  = op;
        r    = $urandom;
        imm  = {{19{r[12]}}, r[12:1], 1'b0};
        rs1  = 5'(1 + $urandom_range(14));
        rs2  = 5'(16 + $urandom_range(15));
        regs[rs1] = a;
        regs[rs2] = b;
        issue(c, 5'd0, rs1, rs2, imm, 1'b1, '0, ref_branch(op, a, b), 1'b1, pc + imm);
    endtask

    task automatic run_jal(input logic [4:0] rd);
        rv32_pkg::decoded_instr_t c;
        rv32_pkg::rv32_word       r;
        rv32_pkg::rv32_word       imm;
        c               = rv32_pkg::create_nop_ctrl();
        c.t             = rv32_pkg::INSTR_J_TYPE;
        c.int_alu_i1    = rv32_pkg::ALU_IN_PC;
        c.branch_op     = rv32_pkg::BR_ALWAYS;
        c.wb_result_src = rv32_pkg::WB_PC4;
        r   = $urandom;
        imm = {{11{r[20]}}, r[20:1], 1'b0};
        issue(c, rd, 5'd0, 5'd0, imm, 1'b1, pc + 32'd4, 1'b1, 1'b1, pc + imm);
    endtask

    task automatic run_mem(input logic store, input logic [4:0] base, input logic [4:0] src,
            input rv32_pkg::rv32_word imm);
        rv32_pkg::decoded_instr_t c;
        rv32_pkg::rv32_word       addr;
        int                       idx;
        c    = rv32_pkg::create_nop_ctrl();
        addr = regs[base] + imm;
        idx  = int'((addr >> 2) % rv32_pkg::DMEM_WORDS);
        if (store) begin
            c.t             = rv32_pkg::INSTR_S_TYPE;
            c.wb_result_src = rv32_pkg::WB_STORE;
            c.mem_write     = 1'b1;
            smem[idx]       = regs[src];
            smem_ok[idx]    = 1'b1;
            issue(c, 5'd0, base, src, imm, 1'b1, regs[src], 1'b0, 1'b0, '0);
        end else begin
            c.wb_result_src = rv32_pkg::WB_LOAD;
            c.mem_read      = 1'b1;
            issue(c, 5'd0, base, 5'd0, imm, smem_ok[idx], smem[idx], 1'b0, 1'b0, '0);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (resetn !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (resetn !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        if (mem_buff.instr !== rv32_pkg::RV_NOP || mem_buff.wb_result !== '0 ||
                mem_buff.decoded_instr.wb_result_src !== rv32_pkg::WB_NONE) begin
            report_mismatch("memory buffer does not hold a NOP after reset");
        end
    endtask

    // Until every check is done and a NOP has reached the memory buffer
    task automatic drain();
        int n;
        n = 0;
        while ((pending_checks() != 0 || mem_buff.instr !== rv32_pkg::RV_NOP) && n < 8) begin
            issue_nop(1'b0);
            n++;
        end
        if (pending_checks() != 0 || mem_buff.instr !== rv32_pkg::RV_NOP) begin
            $display("Timeout: pipeline did not drain");
            timeouts++;
        end
    endtask

    initial begin
        logic [4:0]         rd;
        logic [4:0]         last;
        logic [4:0]         prev;
        logic [4:0]         base;
        rv32_pkg::rv32_word a;
        rv32_pkg::rv32_word b;
        rv32_pkg::rv32_word imm;
        void'($urandom(32'hd9e804e2));
        clk        = 1'b0;
        resetn     = 1'b0;
        mismatches = 0;
        timeouts   = 0;
        decoded_data.instr         = rv32_pkg::RV_NOP;
        decoded_data.pc            = '0;
        decoded_data.decoded_instr = rv32_pkg::create_nop_ctrl();
        decoded_data.reg1          = '0;
        decoded_data.reg2          = '0;
        regs[0] = '0;
        for (int i = 1; i < 32; i++) begin
            regs[i] = $urandom;
        end
        for (int i = 0; i < rv32_pkg::DMEM_WORDS; i++) begin
            smem[i]    = '0;
            smem_ok[i] = 1'b0;
        end
        pc         = $urandom & 32'hffff_fffc;
        prev_rd[0] = 5'd0;
        prev_rd[1] = 5'd0;

        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        wait_reset_release();
        repeat (4) issue_nop(1'b1);

        repeat (3) begin
            for (int i = 0; i <= int'(rv32_pkg::PASS2); i++) begin
                run_alu(rv32_pkg::int_alu_op_t'(i), rv32_pkg::INSTR_R_TYPE,
                        rand_reg(), rand_reg(), rand_reg());
                run_alu(rv32_pkg::int_alu_op_t'(i), rv32_pkg::INSTR_I_TYPE,
                        rand_reg(), rand_reg(), 5'd0);
            end
            run_alu(rv32_pkg::PASS2, rv32_pkg::INSTR_U_TYPE, rand_reg(), 5'd0, 5'd0);
            run_alu(rv32_pkg::ADD, rv32_pkg::INSTR_U_TYPE, rand_reg(), 5'd0, 5'd0);
        end

        // Dependent chains at distance one and two
        last = rand_reg();
        prev = rand_reg();
        for (int i = 0; i < 16; i++) begin
            rd = rand_reg();
            run_alu(rv32_pkg::int_alu_op_t'($urandom_range(10)),
                    (i % 3 == 2) ? rv32_pkg::INSTR_I_TYPE : rv32_pkg::INSTR_R_TYPE,
                    rd, last, prev);
            prev = last;
            last = rd;
        end
        drain();

        for (int op = 1; op <= 6; op++) begin
            for (int k = 0; k < 4; k++) begin
                a = $urandom;
                case (k)
                    0:       b = a;
                    1:       b = a ^ 32'h8000_0000;
                    default: b = $urandom;
                endcase
                run_branch(rv32_pkg::branch_op_t'(op), a, b);
            end
        end
        repeat (4) begin
            rd = rand_reg();
            run_jal(rd);
            run_alu(rv32_pkg::ADD, rv32_pkg::INSTR_R_TYPE, rand_reg(), rd, rand_reg());
        end
        drain();

        for (int i = 0; i < 8; i++) begin
            base = rand_reg();
            imm  = sext12($urandom);
            run_mem(1'b1, base, rand_reg(), imm);
            run_mem(1'b0, base, 5'd0, imm);
        end
        for (int i = 0; i < 40; i++) begin
            base = ($urandom_range(1) == 0) ? 5'd0 : rand_reg();
            run_mem(1'($urandom_range(1)), base, rand_reg(), 32'($urandom_range(15)) << 2);
        end
        drain();

        $display("Mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 mismatches, timeouts, u_dut.u_assert.fail_count);
        if (mismatches + timeouts + u_dut.u_assert.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv32_exec_assert.sv */
/*
 * Concurrent assertions on the execute slice top, bound into it
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_exec_assert (
    input wire                                 clk,
    input wire                                 resetn,
    input wire rv32_pkg::decoded_buffer_data_t decoded_data,
    input wire                                 do_jump,
    input wire rv32_pkg::mem_buffer_data_t     mem_buff
);

    int fail_count = 0;

    // Memory buffer is a NOP right after a reset cycle
    a_reset_nop: assert property (@(posedge clk) !resetn |=>
            mem_buff.decoded_instr.wb_result_src == rv32_pkg::WB_NONE &&
            !mem_buff.decoded_instr.mem_write)
    else begin
        $error("memory buffer is not a NOP one cycle after reset");
        fail_count++;
    end

    a_no_jump: assert property (@(posedge clk) disable iff (!resetn)
            decoded_data.decoded_instr.branch_op == rv32_pkg::BR_NONE |-> !do_jump)
    else begin
        $error("do_jump high without a branch op");
        fail_count++;
    end

    a_always_jump: assert property (@(posedge clk) disable iff (!resetn)
            decoded_data.decoded_instr.branch_op == rv32_pkg::BR_ALWAYS |-> do_jump)
    else begin
        $error("do_jump low on an unconditional jump");
        fail_count++;
    end

endmodule

bind rv32_exec_top rv32_exec_assert u_assert (
    .clk          (clk),
    .resetn       (resetn),
    .decoded_data (decoded_data),
    .do_jump      (do_jump),
    .mem_buff     (mem_buff)
);

`default_nettype wire

/* rv32_exec_top.sv */
/*
 * Execute slice top: execute stage feeding the memory stage,
 * memory buffer looped back for forwarding
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_exec_top (
    input  wire                                  clk,
    input  wire                                  resetn,
    input  wire rv32_pkg::decoded_buffer_data_t  decoded_data,
    output logic                                 do_jump,
    output rv32_pkg::rv32_word                   jump_addr,
    output rv32_pkg::mem_buffer_data_t           mem_buff
);

    rv32_pkg::exec_buffer_data_t exec_data;

    rv32_exec_stage u_exec_stage (
        .clk          (clk),
        .resetn       (resetn),
        .decoded_data (decoded_data),
        .exec_data    (exec_data),
        .do_jump      (do_jump),
        .jump_addr    (jump_addr),
        // Second forwarding source
        .mem_buff     (mem_buff)
    );

    rv32_mem_stage u_mem_stage (
        .clk       (clk),
        .resetn    (resetn),
        .exec_data (exec_data),
        .mem_buff  (mem_buff)
    );

endmodule

`default_nettype wire

/* rv32_mem_stage.sv */
/*
 * Memory stage: word data memory and the memory buffer register
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_mem_stage (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire rv32_pkg::exec_buffer_data_t  exec_data,
    output rv32_pkg::mem_buffer_data_t        mem_buff
);

    rv32_pkg::rv32_word           dmem [rv32_pkg::DMEM_WORDS];
    logic [rv32_pkg::DMEM_AW-1:0] word_idx;
    rv32_pkg::rv32_word           rd_word;
    logic                         wr_en;

    // Word granular, wraps at the memory depth
    assign word_idx = exec_data.mem_addr[2 +: rv32_pkg::DMEM_AW];
    assign rd_word  = dmem[word_idx];
    assign wr_en    = resetn && exec_data.decoded_instr.mem_write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            dmem[word_idx] <= exec_data.wb_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_buff.instr         <= rv32_pkg::RV_NOP;
            mem_buff.pc            <= '0;
            mem_buff.decoded_instr <= rv32_pkg::create_nop_ctrl();
            mem_buff.wb_result     <= '0;
        end else begin
            mem_buff.instr         <= exec_data.instr;
            mem_buff.pc            <= exec_data.pc;
            mem_buff.decoded_instr <= exec_data.decoded_instr;
            if (exec_data.decoded_instr.wb_result_src == rv32_pkg::WB_LOAD) begin
                mem_buff.wb_result <= rd_word;
            end else begin
                mem_buff.wb_result <= exec_data.wb_result;
            end
        end
    end

endmodule

`default_nettype wire

/* rv32_exec_stage.sv */
/*
 * Execute stage: operand forwarding, immediates, ALU, branch
 * resolution and the execute buffer register
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_exec_stage (
    input  wire                                  clk,
    input  wire                                  resetn,
    input  wire rv32_pkg::decoded_buffer_data_t  decoded_data,
    output rv32_pkg::exec_buffer_data_t          exec_data,
    output logic                                 do_jump,
    output rv32_pkg::rv32_word                   jump_addr,
    input  wire rv32_pkg::mem_buffer_data_t      mem_buff
);

    `include "rv_immediates.svh"

    function automatic rv32_pkg::rv32_word operand_mux(
        input rv32_pkg::int_alu_input_t sel,
        input rv32_pkg::rv32_word       rs1,
        input rv32_pkg::rv32_word       rs2,
        input rv32_pkg::rv32_word       pc,
        input rv32_pkg::rv32_word       imm
    );
        rv32_pkg::rv32_word val;
        case (sel)
            rv32_pkg::ALU_IN_REG_1: val = rs1;
            rv32_pkg::ALU_IN_REG_2: val = rs2;
            rv32_pkg::ALU_IN_PC:    val = pc;
            rv32_pkg::ALU_IN_IMM:   val = imm;
            default:                val = '0;
        endcase
        return val;
    endfunction

    rv32_pkg::decoded_instr_t    ctrl;
    rv32_pkg::rv32_word          rs1_val;
    rv32_pkg::rv32_word          rs2_val;
    rv32_pkg::rv32_word          imm;
    rv32_pkg::rv32_word          alu_op1;
    rv32_pkg::rv32_word          alu_op2;
    rv32_pkg::rv32_word          alu_result;
    rv32_pkg::rv32_word          wb_value;

    assign ctrl = decoded_data.decoded_instr;

    // Forwarding from the execute and memory buffers
    always_comb begin
        case (ctrl.bypass_rs1)
            rv32_pkg::BYPASS_EXEC_BUFF: rs1_val = exec_data.wb_result;
            rv32_pkg::BYPASS_MEM_BUFF:  rs1_val = mem_buff.wb_result;
            default:                    rs1_val = decoded_data.reg1;
        endcase
        case (ctrl.bypass_rs2)
            rv32_pkg::BYPASS_EXEC_BUFF: rs2_val = exec_data.wb_result;
            rv32_pkg::BYPASS_MEM_BUFF:  rs2_val = mem_buff.wb_result;
            default:                    rs2_val = decoded_data.reg2;
        endcase
    end

    always_comb begin
        case (ctrl.t)
            rv32_pkg::INSTR_I_TYPE: imm = decode_i_imm(decoded_data.instr);
            rv32_pkg::INSTR_S_TYPE: imm = decode_s_imm(decoded_data.instr);
            rv32_pkg::INSTR_B_TYPE: imm = decode_b_imm(decoded_data.instr);
            rv32_pkg::INSTR_U_TYPE: imm = decode_u_imm(decoded_data.instr);
            rv32_pkg::INSTR_J_TYPE: imm = decode_j_imm(decoded_data.instr);
            default:                imm = '0;
        endcase
    end

    assign alu_op1 = operand_mux(ctrl.int_alu_i1, rs1_val, rs2_val, decoded_data.pc, imm);
    assign alu_op2 = operand_mux(ctrl.int_alu_i2, rs1_val, rs2_val, decoded_data.pc, imm);

    rv32_int_alu u_int_alu (
        .op1    (alu_op1),
        .op2    (alu_op2),
        .opsel  (ctrl.int_alu_op),
        .result (alu_result)
    );

    // Conditions compare the forwarded registers, target comes from the ALU
    rv32_branch_unit u_branch_unit (
        .op1       (rs1_val),
        .op2       (rs2_val),
        .branch_op (ctrl.branch_op),
        .do_branch (do_jump)
    );

    assign jump_addr = alu_result;

    // Load data is filled in by the memory stage
    always_comb begin
        case (ctrl.wb_result_src)
            rv32_pkg::WB_PC4:     wb_value = decoded_data.pc + 32'd4;
            rv32_pkg::WB_INT_ALU: wb_value = alu_result;
            rv32_pkg::WB_STORE:   wb_value = rs2_val;
            default:              wb_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_data.instr         <= rv32_pkg::RV_NOP;
            exec_data.pc            <= '0;
            exec_data.decoded_instr <= rv32_pkg::create_nop_ctrl();
            exec_data.mem_addr      <= '0;
            exec_data.wb_result     <= '0;
        end else begin
            exec_data.instr         <= decoded_data.instr;
            exec_data.pc            <= decoded_data.pc;
            exec_data.decoded_instr <= ctrl;
            exec_data.mem_addr      <= alu_result;
            exec_data.wb_result     <= wb_value;
        end
    end

endmodule

`default_nettype wire

/* rv32_branch_unit.sv */
/*
 * Branch condition evaluation, jumps included
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_branch_unit (
    input  wire rv32_pkg::rv32_word   op1,
    input  wire rv32_pkg::rv32_word   op2,
    input  wire rv32_pkg::branch_op_t branch_op,
    output logic                      do_branch
);

    always_comb begin
        case (branch_op)
            rv32_pkg::BEQ:       do_branch = (op1 == op2);
            rv32_pkg::BNE:       do_branch = (op1 != op2);
            rv32_pkg::BLT:       do_branch = ($signed(op1) < $signed(op2));
            rv32_pkg::BGE:       do_branch = ($signed(op1) >= $signed(op2));
            rv32_pkg::BLTU:      do_branch = (op1 < op2);
            rv32_pkg::BGEU:      do_branch = (op1 >= op2);
            rv32_pkg::BR_ALWAYS: do_branch = 1'b1;
            default:             do_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rv32_int_alu.sv */
/*
 * Combinational RV32I integer ALU
 */
`timescale 1ns/10ps
`default_nettype none

module rv32_int_alu (
    input  wire rv32_pkg::rv32_word    op1,
    input  wire rv32_pkg::rv32_word    op2,
    input  wire rv32_pkg::int_alu_op_t opsel,
    output rv32_pkg::rv32_word         result
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (opsel)
            rv32_pkg::ADD:   result = op1 + op2;
            rv32_pkg::SUB:   result = op1 - op2;
            rv32_pkg::SLL:   result = op1 << shamt;
            rv32_pkg::SLT:   result = {31'b0, $signed(op1) < $signed(op2)};
            rv32_pkg::SLTU:  result = {31'b0, op1 < op2};
            rv32_pkg::XOR:   result = op1 ^ op2;
            rv32_pkg::SRL:   result = op1 >> shamt;
            rv32_pkg::SRA:   result = $unsigned($signed(op1) >>> shamt);
            rv32_pkg::OR:    result = op1 | op2;
            rv32_pkg::AND:   result = op1 & op2;
            // LUI
            rv32_pkg::PASS2: result = op2;
            default:         result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rv32_pkg.sv */
/*
 * Shared types for the RV32I execute slice: words, control enums,
 * pipeline buffer structs, NOP constants and data memory size
 */
`default_nettype none

package rv32_pkg;

    typedef logic [31:0] rv32_word;

    // ADDI x0, x0, 0
    localparam rv32_word RV_NOP = 32'h0000_0013;

    localparam int unsigned DMEM_WORDS = 64;
    localparam int unsigned DMEM_AW    = $clog2(DMEM_WORDS);

    typedef enum logic [2:0] {
        INSTR_R_TYPE,
        INSTR_I_TYPE,
        INSTR_S_TYPE,
        INSTR_B_TYPE,
        INSTR_U_TYPE,
        INSTR_J_TYPE
    } instr_type_t;

    typedef enum logic [2:0] {
        ALU_IN_REG_1,
        ALU_IN_REG_2,
        ALU_IN_PC,
        ALU_IN_IMM,
        ALU_IN_ZERO
    } int_alu_input_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS2
    } int_alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU, BR_ALWAYS
    } branch_op_t;

    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC_BUFF,
        BYPASS_MEM_BUFF
    } bypass_sel_t;

    typedef enum logic [2:0] {
        WB_NONE, WB_PC4, WB_INT_ALU, WB_STORE, WB_LOAD
    } wb_src_t;

    typedef struct packed {
        instr_type_t    t;
        int_alu_input_t int_alu_i1;
        int_alu_input_t int_alu_i2;
        int_alu_op_t    int_alu_op;
        branch_op_t     branch_op;
        bypass_sel_t    bypass_rs1;
        bypass_sel_t    bypass_rs2;
        wb_src_t        wb_result_src;
        logic           mem_write;
        logic           mem_read;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       reg1;
        rv32_word       reg2;
    } decoded_buffer_data_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       mem_addr;
        rv32_word       wb_result;
    } exec_buffer_data_t;

    typedef struct packed {
        rv32_word       instr;
        rv32_word       pc;
        decoded_instr_t decoded_instr;
        rv32_word       wb_result;
    } mem_buffer_data_t;

    // Control with no side effects at all
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t c;
        c.t             = INSTR_I_TYPE;
        c.int_alu_i1    = ALU_IN_REG_1;
        c.int_alu_i2    = ALU_IN_IMM;
        c.int_alu_op    = ADD;
        c.branch_op     = BR_NONE;
        c.bypass_rs1    = BYPASS_NONE;
        c.bypass_rs2    = BYPASS_NONE;
        c.wb_result_src = WB_NONE;
        c.mem_write     = 1'b0;
        c.mem_read      = 1'b0;
        return c;
    endfunction

endpackage

`default_nettype wire

/* rv_immediates.svh */
/*
 * Immediate extraction for the I, S, B, U and J instruction formats
 */
`ifndef RV_IMMEDIATES_SVH
`define RV_IMMEDIATES_SVH

function automatic rv32_pkg::rv32_word decode_i_imm(input rv32_pkg::rv32_word instr);
    return {{20{instr[31]}}, instr[31:20]};
endfunction

function automatic rv32_pkg::rv32_word decode_s_imm(input rv32_pkg::rv32_word instr);
    return {{20{instr[31]}}, instr[31:25], instr[11:7]};
endfunction

// Branch offsets are halfword aligned
function automatic rv32_pkg::rv32_word decode_b_imm(input rv32_pkg::rv32_word instr);
    return {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
endfunction

function automatic rv32_pkg::rv32_word decode_u_imm(input rv32_pkg::rv32_word instr);
    return {instr[31:12], 12'b0};
endfunction

function automatic rv32_pkg::rv32_word decode_j_imm(input rv32_pkg::rv32_word instr);
    return {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
endfunction

`endif
